/* bench/stopwatchTb.sv */
`timescale 1ns/10ps

module stopwatchTb;

  localparam int ClockPeriod = 20;
  localparam int HalfCycles = 8;
  localparam int SecondCycles = 2 * HalfCycles;
  localparam int ResetCycles = 16;
  localparam int SampleOffset = 3;
  localparam int LapPresses = 100;
  // cycle budget per test, rounded up
  localparam int BudgetCycles = ResetCycles + 128 + 64 + 1152 + 256 + 128 + 3456;

  // reference patterns, active low, segment g in bit 6
  localparam logic [6:0] SegTable [10] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
    7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000
  };

  logic        cin;
  logic        reset;
  logic        pause;
  logic        counterOrClockControl;
  logic        increaseOrDecrease;
  logic        setOrStartClock;
  logic [5:0]  setCounter;
  logic [6:0]  tenMin;
  logic [6:0]  oneMin;
  logic [6:0]  tenSec;
  logic [6:0]  oneSec;
  logic [6:0]  tenCounter;
  logic [6:0]  oneCounter;
  logic [31:0] lfsrState;
  int          cycleCount;
  int          errorCount;
  int          checkCount;
  int          expMin;
  int          expSec;
  int          expLap;

  stopwatchTop #(
    .halfTickCycles(HalfCycles)
  ) stopwatchTop_i (
    .cin                  (cin),
    .reset                (reset),
    .pause                (pause),
    .counterOrClockControl(counterOrClockControl),
    .increaseOrDecrease   (increaseOrDecrease),
    .setOrStartClock      (setOrStartClock),
    .setCounter           (setCounter),
    .tenMin               (tenMin),
    .oneMin               (oneMin),
    .tenSec               (tenSec),
    .oneSec               (oneSec),
    .tenCounter           (tenCounter),
    .oneCounter           (oneCounter)
  );

  bind stopwatchTop stopwatchTop_properties properties_i (
    .cin        (cin),
    .reset      (reset),
    .secondTick (secondTick),
    .loadSeconds(loadSeconds),
    .loadMinutes(loadMinutes),
    .advance    (advance),
    .lapCount   (lapCount),
    .seconds    (seconds),
    .minutes    (minutes)
  );

  always #(ClockPeriod / 2) cin = ~cin;

  // cycles since reset release, keeps track of the tick phase
  always @(posedge cin) begin
    if (!reset) begin
      cycleCount <= 0;
    end else begin
      cycleCount <= cycleCount + 1;
    end
  end

  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'hA3000000;
    end
    return shifted;
  endfunction

  task automatic drawBits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      lfsrState = nextLfsr(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
  endtask

  function automatic int decodeSeg(input logic [6:0] pattern);
    int i;
    int digit;
    digit = -1;
    for (i = 0; i < 10; i++) begin
      if (pattern === SegTable[i]) begin
        digit = i;
      end
    end
    return digit;
  endfunction

  // next sample point, 3 cycles past a tick of the given period
  task automatic waitSample(input int period, input int count);
    repeat (count) begin
      @(negedge cin);
      while (cycleCount % period != SampleOffset) begin
        @(negedge cin);
      end
    end
  endtask

  task automatic pressButton();
    pause = 1'b0;
    @(negedge cin);
    pause = 1'b1;
  endtask

  task automatic checkDigit(input string name, input logic [6:0] actual, input int expDigit);
    logic [6:0] expected;
    expected = SegTable[expDigit];
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH %s: expected 0x%02h (digit %0d), got 0x%02h (digit %0d), cycle %0d",
        name, expected, expDigit, actual, decodeSeg(actual), cycleCount);
    end
  endtask

  task automatic checkTime(input int mins, input int secs);
    checkDigit("tenMin", tenMin, mins / 10);
    checkDigit("oneMin", oneMin, mins % 10);
    checkDigit("tenSec", tenSec, secs / 10);
    checkDigit("oneSec", oneSec, secs % 10);
  endtask

  task automatic checkLap(input int lap);
    checkDigit("tenCounter", tenCounter, lap / 10);
    checkDigit("oneCounter", oneCounter, lap % 10);
  endtask

  // one second of the expected clock
  task automatic advanceModel(input logic down);
    if (down) begin
      if (expSec > 0) begin
        expSec--;
      end else if (expMin > 0) begin
        expSec = 59;
        expMin--;
      end
    end else if (expSec == 59) begin
      expSec = 0;
      expMin = (expMin == 59) ? 0 : expMin + 1;
    end else begin
      expSec++;
    end
  endtask

  task automatic runSeconds(input int count, input logic down);
    repeat (count) begin
      waitSample(SecondCycles, 1);
      advanceModel(down);
      checkTime(expMin, expSec);
    end
  endtask

  // set mode load of seconds then minutes, leaves the lockout armed
  task automatic loadTime(input int mins, input int secs);
    setOrStartClock = 1'b1;
    @(negedge cin);
    setOrStartClock = 1'b0;
    setCounter = 6'(secs);
    waitSample(HalfCycles, 1);
    // seconds load clears the minutes
    checkTime(0, secs);
    pressButton();
    setCounter = 6'(mins);
    waitSample(HalfCycles, 4);
    expMin = mins;
    expSec = secs;
    checkTime(expMin, expSec);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    $display("%-20s done, %0d errors", name, errorCount - errorsBefore);
  endtask

  task automatic resetCountUpTest();
    int errorsBefore;
    errorsBefore = errorCount;
    expMin = 0;
    expSec = 0;
    checkTime(0, 0);
    checkLap(0);
    // first sample point, no second tick yet
    waitSample(SecondCycles, 1);
    checkTime(0, 0);
    runSeconds(5, 1'b0);
    reportTest("reset and count-up", errorsBefore);
  endtask

  task automatic setModeTest();
    int errorsBefore;
    int value;
    int firstValue;
    int secondValue;
    errorsBefore = errorCount;
    setOrStartClock = 1'b0;
    drawBits(6, value);
    firstValue = value % 60;
    setCounter = 6'(firstValue);
    waitSample(HalfCycles, 1);
    checkTime(0, firstValue);
    pressButton();
    drawBits(6, value);
    secondValue = value % 60;
    setCounter = 6'(secondValue);
    waitSample(HalfCycles, 1);
    checkTime(secondValue, firstValue);
    // 60 to 63 must not load
    drawBits(2, value);
    setCounter = 6'(60 + value);
    waitSample(HalfCycles, 2);
    checkTime(secondValue, firstValue);
    reportTest("set mode", errorsBefore);
  endtask

  task automatic countDownTest();
    int errorsBefore;
    errorsBefore = errorCount;
    increaseOrDecrease = 1'b1;
    loadTime(1, 1);
    setOrStartClock = 1'b1;
    runSeconds(64, 1'b1);
    reportTest("count down", errorsBefore);
  endtask

  task automatic wrapTest();
    int errorsBefore;
    errorsBefore = errorCount;
    increaseOrDecrease = 1'b0;
    loadTime(59, 58);
    setOrStartClock = 1'b1;
    runSeconds(3, 1'b0);
    loadTime(0, 59);
    setOrStartClock = 1'b1;
    runSeconds(2, 1'b0);
    reportTest("count-up wrap", errorsBefore);
  endtask

  task automatic pauseLockoutTest();
    int errorsBefore;
    errorsBefore = errorCount;
    counterOrClockControl = 1'b0;
    runSeconds(1, 1'b0);
    pressButton();
    repeat (2) @(negedge cin);
    // still locked out, must be ignored
    pressButton();
    repeat (3) begin
      waitSample(SecondCycles, 1);
      checkTime(expMin, expSec);
    end
    pressButton();
    runSeconds(2, 1'b0);
    reportTest("pause and lockout", errorsBefore);
  endtask

  task automatic lapTest();
    int errorsBefore;
    int i;
    errorsBefore = errorCount;
    // freeze the clock so the time digits must hold
    pressButton();
    waitSample(HalfCycles, 4);
    counterOrClockControl = 1'b1;
    checkTime(expMin, expSec);
    expLap = 0;
    for (i = 1; i <= LapPresses; i++) begin
      pressButton();
      waitSample(HalfCycles, 4);
      expLap = (expLap == 99) ? 0 : expLap + 1;
      checkLap(expLap);
      checkTime(expMin, expSec);
    end
    reportTest("lap counter", errorsBefore);
  endtask

  initial begin
    cin = 1'b0;
    reset = 1'b0;
    pause = 1'b1;
    counterOrClockControl = 1'b0;
    increaseOrDecrease = 1'b0;
    setOrStartClock = 1'b1;
    setCounter = '0;
    lfsrState = 32'h74cc;
    errorCount = 0;
    checkCount = 0;
    expLap = 0;
    repeat (ResetCycles) @(negedge cin);
    reset = 1'b1;
    @(negedge cin);
    resetCountUpTest();
    setModeTest();
    countDownTest();
    wrapTest();
    pauseLockoutTest();
    lapTest();
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(2 * BudgetCycles * ClockPeriod);
    $display("watchdog timeout, tests did not finish within %0d cycles", 2 * BudgetCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* bench/stopwatchTop_properties.sv */
`timescale 1ns/10ps

module stopwatchTop_properties (
  input logic                               cin,
  input logic                               reset,
  input logic                               secondTick,
  input logic                               loadSeconds,
  input logic                               loadMinutes,
  input logic                               advance,
  input logic [stopwatchPkg::LapWidth-1:0]  lapCount,
  input logic [stopwatchPkg::TimeWidth-1:0] seconds,
  input logic [stopwatchPkg::TimeWidth-1:0] minutes
);
  import stopwatchPkg::*;

  // at most one time strobe per cycle
  strobesExclusive: assert property (
    @(posedge cin) disable iff (!reset) $onehot0({loadSeconds, loadMinutes, advance})
  ) else $error("time strobes overlap: loadSeconds %b loadMinutes %b advance %b",
    loadSeconds, loadMinutes, advance);

  secondsInRange: assert property (
    @(posedge cin) disable iff (!reset) seconds <= TimeWidth'(MaxTimeValue)
  ) else $error("seconds out of range: 0x%0h", seconds);

  minutesInRange: assert property (
    @(posedge cin) disable iff (!reset) minutes <= TimeWidth'(MaxTimeValue)
  ) else $error("minutes out of range: 0x%0h", minutes);

  lapInRange: assert property (
    @(posedge cin) disable iff (!reset) lapCount <= LapWidth'(MaxLap)
  ) else $error("lap count out of range: 0x%0h", lapCount);

  // the time only moves on a second tick
  advanceOnSecond: assert property (
    @(posedge cin) disable iff (!reset)
      (seconds != $past(seconds)) && !$past(loadSeconds) |-> $past(secondTick)
  ) else $error("seconds moved without a second tick");

endmodule

/* build.f */
rtl/stopwatchPkg.sv
rtl/tickDivider.sv
rtl/panelControl.sv
rtl/timeKeeper.sv
rtl/segmentPair.sv
rtl/stopwatchTop.sv
bench/stopwatchTop_properties.sv
bench/stopwatchTb.sv

/* rtl/panelControl.sv */
`timescale 1ns/10ps

module panelControl (
  input  logic                             cin,
  input  logic                             reset,
  input  logic                             pause,
  input  logic                             counterOrClockControl,
  input  logic                             setOrStartClock,
  input  logic                             halfTick,
  input  logic                             secondTick,
  output logic                             loadSeconds,
  output logic                             loadMinutes,
  output logic                             advance,
  output logic [stopwatchPkg::LapWidth-1:0] lapCount
);
  import stopwatchPkg::*;

  logic                                 armed;
  logic [$clog2(LockoutTicks + 1)-1:0] lockCount;
  logic [FieldWidth-1:0]               field;
  logic                                 paused;
  logic                                 pressAccept;

  // button is active low
  assign pressAccept = ~pause & armed;

  // lockout after each accepted press
  always_ff @(posedge cin) begin
    if (!reset) begin
      armed     <= 1'b1;
      lockCount <= '0;
    end else if (pressAccept) begin
      armed     <= 1'b0;
      lockCount <= '0;
    end else if (!armed && halfTick) begin
      if (lockCount == ($bits(lockCount))'(LockoutTicks - 1)) begin
        armed     <= 1'b1;
        lockCount <= '0;
      end else begin
        lockCount <= lockCount + 1'b1;
      end
    end
  end

  // field selector only lives in set mode
  always_ff @(posedge cin) begin
    if (!reset) begin
      field <= FieldWidth'(FieldSeconds);
    end else if (setOrStartClock) begin
      field <= FieldWidth'(FieldSeconds);
    end else if (pressAccept) begin
      field <= field + 1'b1;
    end
  end

  always_ff @(posedge cin) begin
    if (!reset) begin
      paused <= 1'b0;
    end else if (pressAccept && setOrStartClock && !counterOrClockControl) begin
      paused <= ~paused;
    end
  end

  always_ff @(posedge cin) begin
    if (!reset) begin
      lapCount <= '0;
    end else if (pressAccept && setOrStartClock && counterOrClockControl) begin
      if (lapCount == LapWidth'(MaxLap)) begin
        lapCount <= '0;
      end else begin
        lapCount <= lapCount + LapWidth'(1);
      end
    end
  end

  // strobes follow the ticks directly
  assign loadSeconds = halfTick & ~setOrStartClock & (field == FieldWidth'(FieldSeconds));
  assign loadMinutes = halfTick & ~setOrStartClock & (field == FieldWidth'(FieldMinutes));
  assign advance     = secondTick & setOrStartClock & ~paused;

endmodule

/* rtl/segmentPair.sv */
`timescale 1ns/10ps

module segmentPair (
  input  logic                             cin,
  input  logic                             reset,
  input  logic [stopwatchPkg::LapWidth-1:0] value,
  output logic [stopwatchPkg::SegWidth-1:0] tens,
  output logic [stopwatchPkg::SegWidth-1:0] ones
);
  import stopwatchPkg::*;

  logic [3:0] tensDigit;
  logic [3:0] onesDigit;

  // blank for anything that is not a decimal digit
  function automatic logic [SegWidth-1:0] segOf(input logic [3:0] digit);
    logic [SegWidth-1:0] pattern;
    if (digit <= 4'd9) begin
      pattern = SegDigits[digit];
    end else begin
      pattern = '1;
    end
    return pattern;
  endfunction

  assign tensDigit = 4'(value / LapWidth'(10));
  assign onesDigit = 4'(value % LapWidth'(10));

  always_ff @(posedge cin) begin
    if (!reset) begin
      tens <= SegDigits[0];
      ones <= SegDigits[0];
    end else begin
      tens <= segOf(tensDigit);
      ones <= segOf(onesDigit);
    end
  end

endmodule

/* rtl/stopwatchPkg.sv */
package stopwatchPkg;

  // board clock cycles per half second
  localparam int unsigned HalfTickCycles = 25_000_000;
  localparam int unsigned DividerWidth = 32;

  // minutes and seconds
  localparam int unsigned TimeWidth = 6;
  localparam int unsigned MaxTimeValue = 59;

  // lap counter
  localparam int unsigned LapWidth = 7;
  localparam int unsigned MaxLap = 99;

  // half ticks a press stays locked out
  localparam int unsigned LockoutTicks = 3;

  // set-mode field selector
  localparam int unsigned FieldWidth = 2;
  localparam int unsigned FieldSeconds = 0;
  localparam int unsigned FieldMinutes = 1;

  localparam int unsigned SegWidth = 7;

  // active-low segments, bit 6 is segment g
  localparam logic [SegWidth-1:0] SegDigits [0:9] = '{
    7'b1000000,
    7'b1111001,
    7'b0100100,
    7'b0110000,
    7'b0011001,
    7'b0010010,
    7'b0000010,
    7'b1111000,
    7'b0000000,
    7'b0011000
  };

endpackage

/* rtl/stopwatchTop.sv */
`timescale 1ns/10ps

module stopwatchTop #(
  parameter int unsigned halfTickCycles = stopwatchPkg::HalfTickCycles
) (
  input  logic                              cin,
  input  logic                              reset,
  input  logic                              pause,
  input  logic                              counterOrClockControl,
  input  logic                              increaseOrDecrease,
  input  logic                              setOrStartClock,
  input  logic [stopwatchPkg::TimeWidth-1:0] setCounter,
  output logic [stopwatchPkg::SegWidth-1:0]  tenMin,
  output logic [stopwatchPkg::SegWidth-1:0]  oneMin,
  output logic [stopwatchPkg::SegWidth-1:0]  tenSec,
  output logic [stopwatchPkg::SegWidth-1:0]  oneSec,
  output logic [stopwatchPkg::SegWidth-1:0]  tenCounter,
  output logic [stopwatchPkg::SegWidth-1:0]  oneCounter
);
  import stopwatchPkg::*;

  logic                 halfTick;
  logic                 secondTick;
  logic                 loadSeconds;
  logic                 loadMinutes;
  logic                 advance;
  logic [LapWidth-1:0]  lapCount;
  logic [TimeWidth-1:0] seconds;
  logic [TimeWidth-1:0] minutes;

  tickDivider #(
    .halfTickCycles(halfTickCycles)
  ) tickDivider_i (
    .cin       (cin),
    .reset     (reset),
    .halfTick  (halfTick),
    .secondTick(secondTick)
  );

  panelControl panelControl_i (
    .cin                  (cin),
    .reset                (reset),
    .pause                (pause),
    .counterOrClockControl(counterOrClockControl),
    .setOrStartClock      (setOrStartClock),
    .halfTick             (halfTick),
    .secondTick           (secondTick),
    .loadSeconds          (loadSeconds),
    .loadMinutes          (loadMinutes),
    .advance              (advance),
    .lapCount             (lapCount)
  );

  timeKeeper timeKeeper_i (
    .cin               (cin),
    .reset             (reset),
    .loadSeconds       (loadSeconds),
    .loadMinutes       (loadMinutes),
    .advance           (advance),
    .increaseOrDecrease(increaseOrDecrease),
    .setCounter        (setCounter),
    .seconds           (seconds),
    .minutes           (minutes)
  );

  // time fields widened to the lap width for the shared display pair
  segmentPair minutesDisplay_i (
    .cin  (cin),
    .reset(reset),
    .value(LapWidth'(minutes)),
    .tens (tenMin),
    .ones (oneMin)
  );

  segmentPair secondsDisplay_i (
    .cin  (cin),
    .reset(reset),
    .value(LapWidth'(seconds)),
    .tens (tenSec),
    .ones (oneSec)
  );

  segmentPair lapDisplay_i (
    .cin  (cin),
    .reset(reset),
    .value(lapCount),
    .tens (tenCounter),
    .ones (oneCounter)
  );

endmodule

/* rtl/tickDivider.sv */
`timescale 1ns/10ps

module tickDivider #(
  parameter int unsigned halfTickCycles = stopwatchPkg::HalfTickCycles
) (
  input  logic cin,
  input  logic reset,
  output logic halfTick,
  output logic secondTick
);
  import stopwatchPkg::*;

  logic [DividerWidth-1:0] count;
  logic                    secondPhase;

  always_ff @(posedge cin) begin
    if (!reset) begin
      count    <= '0;
      halfTick <= 1'b0;
    end else if (count == DividerWidth'(halfTickCycles - 1)) begin
      count    <= '0;
      halfTick <= 1'b1;
    end else begin
      count    <= count + DividerWidth'(1);
      halfTick <= 1'b0;
    end
  end

  // flips on every half tick, set means the next one ends a second
  always_ff @(posedge cin) begin
    if (!reset) begin
      secondPhase <= 1'b0;
    end else if (halfTick) begin
      secondPhase <= ~secondPhase;
    end
  end

  assign secondTick = halfTick & secondPhase;

endmodule

/* rtl/timeKeeper.sv */
`timescale 1ns/10ps

module timeKeeper (
  input  logic                              cin,
  input  logic                              reset,
  input  logic                              loadSeconds,
  input  logic                              loadMinutes,
  input  logic                              advance,
  input  logic                              increaseOrDecrease,
  input  logic [stopwatchPkg::TimeWidth-1:0] setCounter,
  output logic [stopwatchPkg::TimeWidth-1:0] seconds,
  output logic [stopwatchPkg::TimeWidth-1:0] minutes
);
  import stopwatchPkg::*;

  logic setValid;
  logic secondsAtMax;
  logic minutesAtMax;
  logic secondsZero;
  logic minutesZero;

  // switch values 60 to 63 load nothing
  assign setValid     = setCounter <= TimeWidth'(MaxTimeValue);
  assign secondsAtMax = seconds == TimeWidth'(MaxTimeValue);
  assign minutesAtMax = minutes == TimeWidth'(MaxTimeValue);
  assign secondsZero  = seconds == '0;
  assign minutesZero  = minutes == '0;

  always_ff @(posedge cin) begin
    if (!reset) begin
      seconds <= '0;
      minutes <= '0;
    end else if (loadSeconds) begin
      if (setValid) begin
        seconds <= setCounter;
        minutes <= '0;
      end
    end else if (loadMinutes) begin
      if (setValid) begin
        minutes <= setCounter;
      end
    end else if (advance) begin
      if (increaseOrDecrease) begin
        // count down, stop at 00:00
        if (!secondsZero) begin
          seconds <= seconds - TimeWidth'(1);
        end else if (!minutesZero) begin
          seconds <= TimeWidth'(MaxTimeValue);
          minutes <= minutes - TimeWidth'(1);
        end
      end else begin
        if (secondsAtMax) begin
          seconds <= '0;
          // 59:59 rolls over to 00:00
          if (minutesAtMax) begin
            minutes <= '0;
          end else begin
            minutes <= minutes + TimeWidth'(1);
          end
        end else begin
          seconds <= seconds + TimeWidth'(1);
        end
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the stopwatch testbench with Verilator, runs it and checks the log.

set -u
cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module stopwatchTb -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/VstopwatchTb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG_FILE"
  exit 1
fi
